// ==== Bender.yml ====
package:
  name: csr_bank

sources:
  - include_dirs:
      - src
    files:
      - src/csr_pkg.sv
      - src/csr_rw_datapath.sv
      - src/csr_machine_regs.sv
      - src/csr_counters.sv
      - src/csr_irq_ctrl.sv
      - src/csr_bank.sv
  - target: test
    files:
      - test/tb_csr_bank.sv

// ==== csr_bank.f ====
+incdir+src
src/csr_pkg.sv
src/csr_rw_datapath.sv
src/csr_machine_regs.sv
src/csr_counters.sv
src/csr_irq_ctrl.sv
src/csr_bank.sv
test/tb_csr_bank.sv

// ==== src/csr_bank.sv ====
//////////////////////////////
// Machine-mode CSR bank, top level
//////////////////////////////
`include "csr_cfg.svh"

module csr_bank (
    input  logic                 clk,
    input  logic                 reset_n,
    input  csr_pkg::csr_access_t access_i,
    input  csr_pkg::trap_req_t   trap_i,
    input  logic                 killed_i,
    input  logic                 hold_i,
    input  csr_pkg::csr_word_t   irq_i,
    output csr_pkg::csr_word_t   rdata_o,
    output logic                 interrupt_pending_o,
    output csr_pkg::priv_e       priv_o,
    output csr_pkg::csr_word_t   mtvec_o,
    output csr_pkg::csr_word_t   mepc_o
);

    csr_pkg::csr_write_t  wr;
    csr_pkg::mach_csr_t   regs;
    csr_pkg::csr_dword_t  cycle;
    csr_pkg::csr_dword_t  instret;
    csr_pkg::csr_word_t   mip;
    csr_pkg::exc_code_t   irq_cause;

    csr_rw_datapath u_rw (
        .access_i  (access_i),
        .trap_i    (trap_i),
        .killed_i  (killed_i),
        .regs_i    (regs),
        .cycle_i   (cycle),
        .instret_i (instret),
        .mip_i     (mip),
        .wr_o      (wr),
        .rdata_o   (rdata_o)
    );

    csr_machine_regs u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .wr_i        (wr),
        .trap_i      (trap_i),
        .irq_cause_i (irq_cause),
        .regs_o      (regs),
        .priv_o      (priv_o)
    );

    csr_counters u_cnt (
        .clk       (clk),
        .reset_n   (reset_n),
        .wr_i      (wr),
        .killed_i  (killed_i),
        .hold_i    (hold_i),
        .cycle_o   (cycle),
        .instret_o (instret)
    );

    csr_irq_ctrl u_irq (
        .clk                 (clk),
        .reset_n             (reset_n),
        .irq_i               (irq_i),
        .mie_i               (regs.mie),
        .mstatus_mie_i       (regs.mstatus[`MSTATUS_MIE_BIT]),
        .int_ack_i           (trap_i.int_ack),
        .mip_o               (mip),
        .irq_cause_o         (irq_cause),
        .interrupt_pending_o (interrupt_pending_o)
    );

    // Trap vector and return address straight from the registers
    assign mtvec_o = regs.mtvec;
    assign mepc_o  = regs.mepc;

endmodule

// ==== src/csr_cfg.svh ====
//////////////////////////////
// CSR addresses, write masks and reset values
// Interrupt bit positions and trap cause codes
//////////////////////////////
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Machine trap setup and handling
`define CSR_ADDR_MSTATUS    12'h300
`define CSR_ADDR_MISA       12'h301
`define CSR_ADDR_MIE        12'h304
`define CSR_ADDR_MTVEC      12'h305
`define CSR_ADDR_MSCRATCH   12'h340
`define CSR_ADDR_MEPC       12'h341
`define CSR_ADDR_MCAUSE     12'h342
`define CSR_ADDR_MTVAL      12'h343
`define CSR_ADDR_MIP        12'h344

// Machine counters
`define CSR_ADDR_MCYCLE     12'hB00
`define CSR_ADDR_MINSTRET   12'hB02
`define CSR_ADDR_MCYCLEH    12'hB80
`define CSR_ADDR_MINSTRETH  12'hB82

// Identity registers, read as zero
`define CSR_ADDR_MVENDORID  12'hF11
`define CSR_ADDR_MARCHID    12'hF12
`define CSR_ADDR_MIMPID     12'hF13
`define CSR_ADDR_MHARTID    12'hF14
`define CSR_ADDR_MCONFIGPTR 12'hF15

`define CSR_MASK_MSTATUS    32'h007E19AA
`define CSR_MASK_MISA       32'h00301000
`define CSR_MASK_MIE        32'h00000888
`define CSR_MASK_MTVEC      32'hFFFFFFFC
`define CSR_MASK_MEPC       32'hFFFFFFFC
`define CSR_MASK_FULL       32'hFFFFFFFF

`define CSR_MISA_RESET      32'h40101100   // RV32 I, M, U

`define MSTATUS_MIE_BIT     3
`define MSTATUS_MPIE_BIT    7
`define MSTATUS_MPP_LSB     11

`define IRQ_BIT_MEI         11
`define IRQ_BIT_MSI         3
`define IRQ_BIT_MTI         7

`define CAUSE_M_EXT         5'd11
`define CAUSE_M_SW          5'd3
`define CAUSE_M_TIM         5'd7

`define EXC_ILLEGAL_INSTR   5'd2

`endif

// ==== src/csr_counters.sv ====
//////////////////////////////
// 64-bit mcycle and minstret counters
//////////////////////////////
`include "csr_cfg.svh"

module csr_counters (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::csr_write_t wr_i,
    input  logic                killed_i,
    input  logic                hold_i,
    output csr_pkg::csr_dword_t cycle_o,
    output csr_pkg::csr_dword_t instret_o
);

    // Increment, then let a CSR write replace one half
    function automatic csr_pkg::csr_dword_t count_next(
        input csr_pkg::csr_dword_t cur,
        input logic                inc,
        input csr_pkg::csr_write_t wr,
        input csr_pkg::csr_addr_t  lo_addr,
        input csr_pkg::csr_addr_t  hi_addr
    );
        csr_pkg::csr_dword_t nxt;
        nxt = inc ? cur + 64'd1 : cur;
        if (wr.en && wr.addr == lo_addr)
            nxt[31:0] = wr.data;
        if (wr.en && wr.addr == hi_addr)
            nxt[63:32] = wr.data;
        return nxt;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cycle_o   <= '0;
            instret_o <= '0;
        end else begin
            cycle_o   <= count_next(cycle_o, 1'b1, wr_i, `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH);
            instret_o <= count_next(instret_o, !(killed_i || hold_i), wr_i,
                                    `CSR_ADDR_MINSTRET, `CSR_ADDR_MINSTRETH);
        end
    end

endmodule

// ==== src/csr_irq_ctrl.sv ====
//////////////////////////////
// Interrupt sampling, pending flag
// and fixed-priority cause select
//////////////////////////////
`include "csr_cfg.svh"

module csr_irq_ctrl (
    input  logic               clk,
    input  logic               reset_n,
    input  csr_pkg::csr_word_t irq_i,
    input  csr_pkg::csr_word_t mie_i,
    input  logic               mstatus_mie_i,
    input  logic               int_ack_i,
    output csr_pkg::csr_word_t mip_o,
    output csr_pkg::exc_code_t irq_cause_o,
    output logic               interrupt_pending_o
);

    csr_pkg::csr_word_t irq_active;

    assign irq_active = mie_i & mip_o;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mip_o               <= '0;
            irq_cause_o         <= '0;
            interrupt_pending_o <= 1'b0;
        end else begin
            mip_o <= irq_i;                     // One cycle of sampling
            if (mstatus_mie_i && (irq_active != '0) && !int_ack_i) begin
                interrupt_pending_o <= 1'b1;
                // External first, then software, then timer
                if (irq_active[`IRQ_BIT_MEI])
                    irq_cause_o <= `CAUSE_M_EXT;
                else if (irq_active[`IRQ_BIT_MSI])
                    irq_cause_o <= `CAUSE_M_SW;
                else if (irq_active[`IRQ_BIT_MTI])
                    irq_cause_o <= `CAUSE_M_TIM;
            end else begin
                interrupt_pending_o <= 1'b0;
            end
        end
    end

    a_pending_needs_mie: assert property (
        @(posedge clk) disable iff (!reset_n)
        interrupt_pending_o |-> $past(mstatus_mie_i)
    );

endmodule

// ==== src/csr_machine_regs.sv ====
//////////////////////////////
// Machine trap registers and privilege
// Trap entry, mret and CSR write updates
//////////////////////////////
`include "csr_cfg.svh"

module csr_machine_regs (
    input  logic                clk,
    input  logic                reset_n,
    input  csr_pkg::csr_write_t wr_i,
    input  csr_pkg::trap_req_t  trap_i,
    input  csr_pkg::exc_code_t  irq_cause_i,
    output csr_pkg::mach_csr_t  regs_o,
    output csr_pkg::priv_e      priv_o
);

    csr_pkg::csr_word_t misa;
    csr_pkg::csr_word_t mstatus;   // Only the masked bits ever get set
    csr_pkg::csr_word_t mie;
    csr_pkg::csr_word_t mtvec;
    csr_pkg::csr_word_t mscratch;
    csr_pkg::csr_word_t mepc;
    csr_pkg::csr_word_t mcause;
    csr_pkg::csr_word_t mtval;
    csr_pkg::priv_e     priv;

    //////////////////////////////
    // Register updates
    //////////////////////////////
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            misa     <= `CSR_MISA_RESET;
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            priv     <= csr_pkg::PRIV_MACHINE;
        end else begin
            if (trap_i.mret) begin
                mstatus[`MSTATUS_MIE_BIT] <= mstatus[`MSTATUS_MPIE_BIT];
                priv <= csr_pkg::priv_e'(mstatus[`MSTATUS_MPP_LSB +: 2]);
            end else if (trap_i.exception) begin
                mcause <= {1'b0, 26'b0, trap_i.exc_code};
                mepc   <= trap_i.pc;
                mtval  <= (trap_i.exc_code == `EXC_ILLEGAL_INSTR) ? trap_i.instr : trap_i.pc;
                mstatus[`MSTATUS_MPP_LSB +: 2] <= priv;
                mstatus[`MSTATUS_MPIE_BIT]     <= mstatus[`MSTATUS_MIE_BIT];
                mstatus[`MSTATUS_MIE_BIT]      <= 1'b0;
                priv   <= csr_pkg::PRIV_MACHINE;
            end else if (trap_i.int_ack) begin
                mcause <= {1'b1, 26'b0, irq_cause_i};
                // The current instruction retires, so resume after it
                mepc   <= trap_i.jump ? trap_i.jump_target : trap_i.pc + 32'd4;
                mstatus[`MSTATUS_MPP_LSB +: 2] <= priv;
                mstatus[`MSTATUS_MPIE_BIT]     <= mstatus[`MSTATUS_MIE_BIT];
                mstatus[`MSTATUS_MIE_BIT]      <= 1'b0;
                priv   <= csr_pkg::PRIV_MACHINE;
            end

            // Strobe is already low in any trap cycle
            if (wr_i.en) begin
                case (wr_i.addr)
                    `CSR_ADDR_MSTATUS:  mstatus  <= wr_i.data;
                    `CSR_ADDR_MISA:     misa     <= wr_i.data;
                    `CSR_ADDR_MIE:      mie      <= wr_i.data;
                    `CSR_ADDR_MTVEC:    mtvec    <= wr_i.data;
                    `CSR_ADDR_MSCRATCH: mscratch <= wr_i.data;
                    `CSR_ADDR_MEPC:     mepc     <= wr_i.data;
                    `CSR_ADDR_MCAUSE:   mcause   <= wr_i.data;
                    `CSR_ADDR_MTVAL:    mtval    <= wr_i.data;
                    default: ;                  // Counters live elsewhere
                endcase
            end
        end
    end

    assign regs_o.misa     = misa;
    assign regs_o.mstatus  = mstatus;
    assign regs_o.mie      = mie;
    assign regs_o.mtvec    = mtvec;
    assign regs_o.mscratch = mscratch;
    assign regs_o.mepc     = mepc;
    assign regs_o.mcause   = mcause;
    assign regs_o.mtval    = mtval;
    assign priv_o          = priv;

    // Trap entry always lands in machine mode
    a_exc_to_machine: assert property (
        @(posedge clk) disable iff (!reset_n)
        (trap_i.exception && !trap_i.mret) |=> (priv_o == csr_pkg::PRIV_MACHINE)
    );

endmodule

// ==== src/csr_pkg.sv ====
//////////////////////////////
// CSR bank types: data words, enums
// and the structs passed between units
//////////////////////////////
package csr_pkg;

    typedef logic [31:0] csr_word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] csr_dword_t;
    typedef logic [4:0]  exc_code_t;

    // Matches the low bits of funct3
    typedef enum logic [1:0] {
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    typedef struct packed {
        logic      rd;
        logic      wr;
        csr_op_e   op;
        csr_addr_t addr;
        csr_word_t data;
    } csr_access_t;

    typedef struct packed {
        logic      exception;
        exc_code_t exc_code;
        logic      mret;
        logic      int_ack;
        csr_word_t pc;
        csr_word_t instr;
        logic      jump;
        csr_word_t jump_target;
    } trap_req_t;

    // Gated write, already merged under the mask
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_word_t data;
    } csr_write_t;

    typedef struct packed {
        csr_word_t misa;
        csr_word_t mstatus;
        csr_word_t mie;
        csr_word_t mtvec;
        csr_word_t mscratch;
        csr_word_t mepc;
        csr_word_t mcause;
        csr_word_t mtval;
    } mach_csr_t;

endpackage

// ==== src/csr_rw_datapath.sv ====
//////////////////////////////
// CSR access datapath: write gating,
// masked modify and read multiplexer
//////////////////////////////
`include "csr_cfg.svh"

module csr_rw_datapath (
    input  csr_pkg::csr_access_t access_i,
    input  csr_pkg::trap_req_t   trap_i,
    input  logic                 killed_i,
    input  csr_pkg::mach_csr_t   regs_i,
    input  csr_pkg::csr_dword_t  cycle_i,
    input  csr_pkg::csr_dword_t  instret_i,
    input  csr_pkg::csr_word_t   mip_i,
    output csr_pkg::csr_write_t  wr_o,
    output csr_pkg::csr_word_t   rdata_o
);

    csr_pkg::csr_word_t cur_val;
    csr_pkg::csr_word_t wmask;
    csr_pkg::csr_word_t new_val;
    logic               trap_active;

    // Any trap in this cycle wins over the CSR write
    assign trap_active = trap_i.exception | trap_i.mret | trap_i.int_ack;

    //////////////////////////////
    // Current value and mask
    //////////////////////////////
    always_comb begin
        cur_val = '0;
        wmask   = '0;   // Unknown address, nothing writable
        case (access_i.addr)
            `CSR_ADDR_MSTATUS:   begin cur_val = regs_i.mstatus;    wmask = `CSR_MASK_MSTATUS; end
            `CSR_ADDR_MISA:      begin cur_val = regs_i.misa;       wmask = `CSR_MASK_MISA;    end
            `CSR_ADDR_MIE:       begin cur_val = regs_i.mie;        wmask = `CSR_MASK_MIE;     end
            `CSR_ADDR_MTVEC:     begin cur_val = regs_i.mtvec;      wmask = `CSR_MASK_MTVEC;   end
            `CSR_ADDR_MSCRATCH:  begin cur_val = regs_i.mscratch;   wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MEPC:      begin cur_val = regs_i.mepc;       wmask = `CSR_MASK_MEPC;    end
            `CSR_ADDR_MCAUSE:    begin cur_val = regs_i.mcause;     wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MTVAL:     begin cur_val = regs_i.mtval;      wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MCYCLE:    begin cur_val = cycle_i[31:0];     wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MCYCLEH:   begin cur_val = cycle_i[63:32];    wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MINSTRET:  begin cur_val = instret_i[31:0];   wmask = `CSR_MASK_FULL;    end
            `CSR_ADDR_MINSTRETH: begin cur_val = instret_i[63:32];  wmask = `CSR_MASK_FULL;    end
            default: ;
        endcase
    end

    always_comb begin
        case (access_i.op)
            csr_pkg::CSR_OP_SET:   new_val = cur_val | (access_i.data & wmask);
            csr_pkg::CSR_OP_CLEAR: new_val = cur_val & ~(access_i.data & wmask);
            default:               new_val = (cur_val & ~wmask) | (access_i.data & wmask);
        endcase
    end

    assign wr_o.en   = access_i.wr & ~killed_i & ~trap_active;
    assign wr_o.addr = access_i.addr;
    assign wr_o.data = new_val;

    //////////////////////////////
    // Read multiplexer
    //////////////////////////////
    always_comb begin
        rdata_o = '0;
        if (access_i.rd && !killed_i) begin
            case (access_i.addr)
                `CSR_ADDR_MSTATUS:   rdata_o = regs_i.mstatus;
                `CSR_ADDR_MISA:      rdata_o = regs_i.misa;
                `CSR_ADDR_MIE:       rdata_o = regs_i.mie;
                `CSR_ADDR_MTVEC:     rdata_o = regs_i.mtvec;
                `CSR_ADDR_MSCRATCH:  rdata_o = regs_i.mscratch;
                `CSR_ADDR_MEPC:      rdata_o = regs_i.mepc;
                `CSR_ADDR_MCAUSE:    rdata_o = regs_i.mcause;
                `CSR_ADDR_MTVAL:     rdata_o = regs_i.mtval;
                `CSR_ADDR_MIP:       rdata_o = mip_i;
                `CSR_ADDR_MCYCLE:    rdata_o = cycle_i[31:0];
                `CSR_ADDR_MCYCLEH:   rdata_o = cycle_i[63:32];
                `CSR_ADDR_MINSTRET:  rdata_o = instret_i[31:0];
                `CSR_ADDR_MINSTRETH: rdata_o = instret_i[63:32];
                // Identity registers have no implementation id
                `CSR_ADDR_MVENDORID, `CSR_ADDR_MARCHID, `CSR_ADDR_MIMPID,
                `CSR_ADDR_MHARTID, `CSR_ADDR_MCONFIGPTR: rdata_o = '0;
                default:             rdata_o = '0;
            endcase
        end
    end

endmodule

// ==== test/csr_golden.txt ====
# Hex fields. W addr op(1 wr,2 set,3 clr) data | R addr expect | E code pc instr waddr wdata
# M | I irq | A jump target pc | K addr | N n | H n | P pend | V priv | C addr | D addr delta
R 301 40101100
R F11 00000000
R 7C0 00000000
W 340 1 DEADBEEF
W 340 2 00000011
W 340 3 000000F0
R 340 DEADBE0F
W 304 1 FFFFFFFF
W 304 3 00000008
R 304 00000880
W 305 1 80000103
W 305 2 00000013
R 305 80000110
W 300 1 FFFFFFFF
R 300 007E19AA
W 300 1 00000008
E 02 00001000 DEADC0DE 000 00000000
R 342 00000002
R 341 00001000
R 343 DEADC0DE
R 300 00001880
E 04 00002002 12345678 000 00000000
R 342 00000004
R 341 00002002
R 343 00002002
R 300 00001800
W 300 1 00000080
M
V 0
R 300 00000088
I 00000880
P 0
P 1
A 0 00000000 00003000
R 342 8000000B
R 341 00003004
V 3
W 300 2 00000008
R 300 00000088
P 1
A 1 00004000 00003100
R 341 00004000
K 340
R 340 DEADBE0F
E 02 00005000 00000013 340 11111111
R 340 DEADBE0F
C B00
N 5
D B00 6
C B02
H 4
D B02 1

// ==== test/tb_csr_bank.sv ====
//////////////////////////////
// CSR bank testbench
// Golden command player, value checks
// and a watchdog
//////////////////////////////
module tb_csr_bank;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLES_PER_CMD = 20;
    localparam int RESET_CYCLES   = 4;
    localparam int CLK_PERIOD     = 10;

    logic                 clk;
    logic                 reset_n;
    csr_pkg::csr_access_t access;
    csr_pkg::trap_req_t   trap;
    logic                 killed;
    logic                 hold;
    csr_pkg::csr_word_t   irq;
    csr_pkg::csr_word_t   rdata;
    logic                 pending;
    csr_pkg::priv_e       priv;
    csr_pkg::csr_word_t   mtvec;
    csr_pkg::csr_word_t   mepc;

    string       cmd_q[$];          // Command lines without comments
    int          limit_cycles = 0;
    logic [31:0] lfsr;
    logic [31:0] mark;              // Counter value taken by a C line

    csr_bank u_dut (
        .clk                 (clk),
        .reset_n             (reset_n),
        .access_i            (access),
        .trap_i              (trap),
        .killed_i            (killed),
        .hold_i              (hold),
        .irq_i               (irq),
        .rdata_o             (rdata),
        .interrupt_pending_o (pending),
        .priv_o              (priv),
        .mtvec_o             (mtvec),
        .mepc_o              (mepc)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %08h, actual %08h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Right-shift Galois form, taps for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'hA300_0000 : 32'h0);
    endfunction

    // Rising edge, every strobe back to idle
    task automatic start_cycle();
        @(posedge clk);
        access.rd   <= 1'b0;
        access.wr   <= 1'b0;
        access.op   <= csr_pkg::CSR_OP_WRITE;
        access.addr <= '0;
        access.data <= '0;
        trap        <= '0;
        killed      <= 1'b0;
        hold        <= 1'b0;
    endtask

    task automatic run_command(input string line, input int num);
        byte         cmd;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] fill;
        string       name;
        cmd = line.getc(0);
        f0 = '0;
        f1 = '0;
        f2 = '0;
        f3 = '0;
        f4 = '0;
        void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h", f0, f1, f2, f3, f4));
        name = $sformatf("command %0d (%c %h)", num, cmd, f0);
        start_cycle();
        case (cmd)
            "W": begin
                access.wr   <= 1'b1;
                access.op   <= csr_pkg::csr_op_e'(f1[1:0]);
                access.addr <= f0[11:0];
                access.data <= f2;
            end
            "R", "C", "D": begin
                access.rd   <= 1'b1;
                access.addr <= f0[11:0];
            end
            "E": begin
                trap.exception <= 1'b1;
                trap.exc_code  <= f0[4:0];
                trap.pc        <= f1;
                trap.instr     <= f2;
                access.wr      <= (f3 != '0);   // Same-cycle write, must be dropped
                access.addr    <= f3[11:0];
                access.data    <= f4;
            end
            "M": trap.mret <= 1'b1;
            "I": irq <= f0;                     // Level, stays until the next I line
            "A": begin
                trap.int_ack     <= 1'b1;
                trap.jump        <= f0[0];
                trap.jump_target <= f1;
                trap.pc          <= f2;
            end
            "K": begin
                for (int b = 0; b < 32; b++) begin
                    lfsr    = lfsr_step(lfsr);
                    fill[b] = lfsr[0];
                end
                access.wr   <= 1'b1;
                access.addr <= f0[11:0];
                access.data <= fill;
                killed      <= 1'b1;
            end
            "N", "H": begin
                hold <= (cmd == "H");
                for (int i = 1; i < f0; i++) begin
                    start_cycle();
                    hold <= (cmd == "H");
                end
            end
            "P", "V": ;
            default: begin
                $display("Unknown command '%c' in golden command %0d", cmd, num);
                $display("TEST FAILED");
                $fatal(1, "bad stimulus command");
            end
        endcase
        @(negedge clk);                         // Outputs settled
        case (cmd)
            "R": begin
                check_value(name, f1, rdata);
                // mtvec and mepc also leave as register outputs
                if (f0[11:0] == 12'h305)
                    check_value({name, " mtvec_o"}, f1, mtvec);
                if (f0[11:0] == 12'h341)
                    check_value({name, " mepc_o"}, f1, mepc);
            end
            "C": mark = rdata;
            "D": check_value(name, f1, rdata - mark);
            "P": check_value(name, f0, {31'b0, pending});
            "V": check_value(name, f0, {30'b0, priv});
            default: ;
        endcase
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int    fd;
        string line;
        clk         = 1'b0;
        reset_n     = 1'b0;
        access      = '0;
        access.op   = csr_pkg::CSR_OP_WRITE;
        trap        = '0;
        killed      = 1'b0;
        hold        = 1'b0;
        irq         = '0;
        lfsr        = 32'h58e3;
        mark        = '0;
        fd = $fopen("test/csr_golden.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file test/csr_golden.txt");
            $display("TEST FAILED");
            $fatal(1, "missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#")
                    cmd_q.push_back(line);
            end
        end
        $fclose(fd);
        limit_cycles = cmd_q.size() * CYCLES_PER_CMD + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;

        foreach (cmd_q[i])
            run_command(cmd_q[i], i + 1);

        start_cycle();
        $display("TEST PASSED");
        $finish;
    end

    // Watchdog, armed once the command count is known
    initial begin
        wait (limit_cycles > 0);
        #(limit_cycles * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run hung", limit_cycles);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule
